// File: i2c_pkg.sv
`default_nettype none

package i2c_pkg;

  // 100 kHz bus from a 50 MHz clk
  localparam logic [15:0] clk_div_default = 16'd125;

  // Quarter-bit phases of one SCL period
  // SDA may change only around the first low quarter
  typedef enum logic [1:0] {
    ph_scl_low0  = 2'd0,  // SCL low, data may change at its end
    ph_scl_low1  = 2'd1,  // SCL low, data settled
    ph_scl_high0 = 2'd2,  // SCL high, sampled at its end
    ph_scl_high1 = 2'd3   // SCL high, wraps back to low0
  } phase_t;

  // Transaction sequencing of the master
  typedef enum logic [3:0] {
    st_idle       = 4'd0,   // Bus free, waiting for start
    st_start      = 4'd1,   // SDA falls while SCL is high
    st_addr       = 4'd2,   // 7 address bits, MSB first
    st_rw         = 4'd3,   // Direction bit
    st_target_ack = 4'd4,   // Target pulls SDA low to accept
    st_write_msb  = 4'd5,   // Upper data byte out
    st_write_lsb  = 4'd6,   // Lower data byte out
    st_read_msb   = 4'd7,   // Upper data byte in
    st_read_lsb   = 4'd8,   // Lower data byte in
    st_master_ack = 4'd9,   // Ack after first read byte, nack after last
    st_stop       = 4'd10   // SDA rises while SCL is high
  } xfer_state_t;

endpackage

`default_nettype wire

// File: i2c_scl_gen.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_scl_gen #(
  parameter logic [15:0] clk_div = i2c_pkg::clk_div_default
) (
  input  wire             clk,
  input  wire             rst,
  input  wire             run,
  input  wire             scl_in,
  output logic            tick,
  output i2c_pkg::phase_t phase,
  output logic            scl_oe
);

  import i2c_pkg::*;

  logic [15:0] cnt;      // clk cycles into the current quarter
  logic        stretch;  // Target still holds SCL low

  // SCL was released but the bus has not risen yet
  assign stretch = ((phase == ph_scl_high0) || (phase == ph_scl_high1)) && !scl_in;

  // Marks the last cycle of the current phase
  assign tick = !stretch && (cnt == clk_div - 16'd1);

  // Pull SCL low for the two low quarters only
  assign scl_oe = run && ((phase == ph_scl_low0) || (phase == ph_scl_low1));

  always_ff @(posedge clk)
  begin
    if (rst || !run)
    begin
      cnt   <= '0;
      phase <= ph_scl_high0;  // Bus idles with SCL released
    end
    else if (!stretch)
    begin
      if (tick)
      begin
        cnt   <= '0;
        phase <= phase_t'(phase + 2'd1);  // high1 wraps to low0
      end
      else
      begin
        cnt <= cnt + 16'd1;
      end
    end
  end

  // The master only drops run on a phase boundary, so the divider
  // must already be cleared whenever run is low
  assert property (@(posedge clk) disable iff (rst) !run |-> !tick)
    else $error("scl_gen tick while run is low");

endmodule

`default_nettype wire

// File: i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master (
  input  wire             clk,
  input  wire             rst,
  input  wire             start,
  input  wire  [6:0]      addr,
  input  wire  [15:0]     data,
  input  wire             two_bytes,
  input  wire             rw,         // 0 write, 1 read
  input  wire             tick,
  input  wire i2c_pkg::phase_t phase,
  input  wire             sda_in,
  output logic            run,
  output logic            sda_oe,
  output logic [15:0]     read_data,
  output logic            ready,
  output logic            nack
);

  import i2c_pkg::*;

  xfer_state_t state;
  logic [6:0]  addr_q;
  logic [15:0] data_q;       // Write data out, read data in
  logic        rw_q;
  logic        two_bytes_q;  // Another byte follows the current one
  logic        addr_acked;   // Address phase is behind us
  logic [2:0]  bit_cnt;
  logic        drive_tick;
  logic        sample_tick;
  logic        accept;

  // Bit boundary, SCL is low and SDA may move
  assign drive_tick = tick && (phase == ph_scl_low0);

  // Middle of the SCL high time
  assign sample_tick = tick && (phase == ph_scl_high0);

  assign accept    = start && (state == st_idle);
  assign run       = (state != st_idle);
  assign ready     = (state == st_idle);
  assign read_data = data_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= st_idle;
      sda_oe      <= 1'b0;
      nack        <= 1'b0;
      two_bytes_q <= 1'b0;
      addr_acked  <= 1'b0;
      bit_cnt     <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (accept)
          begin
            state       <= st_start;
            nack        <= 1'b0;  // Sticky flag lives until the next start
            two_bytes_q <= two_bytes;
            addr_acked  <= 1'b0;
          end
        end

        st_start:
        begin
          if (sample_tick)
          begin
            sda_oe <= 1'b1;  // Start condition
          end
          else if (drive_tick)
          begin
            state   <= st_addr;
            bit_cnt <= 3'd6;
            sda_oe  <= ~addr_q[6];
          end
        end

        st_addr:
        begin
          if (drive_tick)
          begin
            if (bit_cnt == 3'd0)
            begin
              state  <= st_rw;
              sda_oe <= ~rw_q;
            end
            else
            begin
              bit_cnt <= bit_cnt - 3'd1;
              sda_oe  <= ~addr_q[bit_cnt - 3'd1];
            end
          end
        end

        st_rw:
        begin
          if (drive_tick)
          begin
            state  <= st_target_ack;
            sda_oe <= 1'b0;  // Hand SDA to the target
          end
        end

        st_target_ack:
        begin
          if (sample_tick)
          begin
            if (sda_in)
            begin
              nack <= 1'b1;  // Nobody answered
            end
          end
          else if (drive_tick)
          begin
            if (nack)
            begin
              state  <= st_stop;
              sda_oe <= 1'b1;
            end
            else if (!addr_acked)
            begin
              addr_acked <= 1'b1;
              bit_cnt    <= 3'd7;
              if (rw_q)
              begin
                state <= two_bytes_q ? st_read_msb : st_read_lsb;
              end
              else if (two_bytes_q)
              begin
                state  <= st_write_msb;
                sda_oe <= ~data_q[15];
              end
              else
              begin
                state  <= st_write_lsb;
                sda_oe <= ~data_q[7];
              end
            end
            else if (two_bytes_q)
            begin
              two_bytes_q <= 1'b0;  // Lower byte is the last one
              state       <= st_write_lsb;
              bit_cnt     <= 3'd7;
              sda_oe      <= ~data_q[7];
            end
            else
            begin
              state  <= st_stop;
              sda_oe <= 1'b1;
            end
          end
        end

        st_write_msb, st_write_lsb:
        begin
          if (drive_tick)
          begin
            if (bit_cnt == 3'd0)
            begin
              state  <= st_target_ack;
              sda_oe <= 1'b0;
            end
            else
            begin
              bit_cnt <= bit_cnt - 3'd1;
              sda_oe  <= ~data_q[{state == st_write_msb, bit_cnt - 3'd1}];
            end
          end
        end

        st_read_msb, st_read_lsb:
        begin
          if (drive_tick)
          begin
            if (bit_cnt == 3'd0)
            begin
              state  <= st_master_ack;
              sda_oe <= (state == st_read_msb);  // Ack only if more follows
            end
            else
            begin
              bit_cnt <= bit_cnt - 3'd1;
            end
          end
        end

        st_master_ack:
        begin
          if (drive_tick)
          begin
            if (two_bytes_q)
            begin
              two_bytes_q <= 1'b0;
              state       <= st_read_lsb;
              bit_cnt     <= 3'd7;
              sda_oe      <= 1'b0;
            end
            else
            begin
              state  <= st_stop;
              sda_oe <= 1'b1;  // Hold SDA low so it can rise later
            end
          end
        end

        st_stop:
        begin
          if (sample_tick)
          begin
            state  <= st_idle;
            sda_oe <= 1'b0;  // Stop condition
          end
        end

        default:
        begin
          state  <= st_idle;
          sda_oe <= 1'b0;
        end
      endcase
    end
  end

  // Request capture and read shift register
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q <= addr;
      data_q <= rw ? '0 : data;  // Reads start from a clean buffer
      rw_q   <= rw;
    end
    else if (sample_tick && ((state == st_read_msb) || (state == st_read_lsb)))
    begin
      data_q[{state == st_read_msb, bit_cnt}] <= sda_in;
    end
  end

  // Host pulsed start during a transaction, the request is dropped
  assert property (@(posedge clk) disable iff (rst) start |-> ready)
    else $warning("start ignored while a transaction is in flight");

  // Data moves only while SCL is low, start and stop excepted
  assert property (@(posedge clk) disable iff (rst)
    $changed(sda_oe) |-> (phase == ph_scl_low1) || ($past(state) inside {st_start, st_stop}))
    else $error("SDA changed while SCL was high");

endmodule

`default_nettype wire

// File: i2c_sub_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_sub_top #(
  parameter logic [15:0] clk_div = i2c_pkg::clk_div_default
) (
  input  wire        clk,
  input  wire        rst,
  input  wire        start,
  input  wire [6:0]  addr,
  input  wire [15:0] data,
  input  wire        two_bytes,
  input  wire        rw,
  input  wire        scl_in,     // Resolved bus level
  input  wire        sda_in,     // Resolved bus level
  output wire        scl_oe,     // 1 pulls SCL low
  output wire        sda_oe,     // 1 pulls SDA low
  output wire [15:0] read_data,
  output wire        ready,
  output wire        nack
);

  import i2c_pkg::*;

  wire    run;
  wire    tick;
  phase_t phase;

  i2c_scl_gen #(
    .clk_div (clk_div)
  ) scl_gen_i (
    .clk    (clk),
    .rst    (rst),
    .run    (run),
    .scl_in (scl_in),
    .tick   (tick),
    .phase  (phase),
    .scl_oe (scl_oe)
  );

  i2c_master master_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .addr      (addr),
    .data      (data),
    .two_bytes (two_bytes),
    .rw        (rw),
    .tick      (tick),
    .phase     (phase),
    .sda_in    (sda_in),
    .run       (run),
    .sda_oe    (sda_oe),
    .read_data (read_data),
    .ready     (ready),
    .nack      (nack)
  );

  // An idle master leaves both lines to the pull-ups
  assert property (@(posedge clk) disable iff (rst)
    (master_i.state == st_idle) |-> (!scl_oe && !sda_oe))
    else $error("bus pulled low while the master is idle");

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int period_ns = 4
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(period_ns / 2) clk = ~clk;  // Toggle every half period
    end
  end

endmodule

`default_nettype wire

// File: i2c_target_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_target_model #(
  parameter logic [6:0] dev_addr    = 7'h50,
  parameter int         hold_cycles = 10     // SCL low time held from each ninth fall
) (
  input  wire  clk,
  input  wire  rst,
  input  wire  scl,     // Resolved bus
  input  wire  sda,     // Resolved bus
  output logic scl_oe,  // 1 pulls SCL low
  output logic sda_oe   // 1 pulls SDA low
);

  logic        scl_q;
  logic        sda_q;
  logic        scl_rise;
  logic        scl_fall;
  logic        start_cond;
  logic        stop_cond;
  logic        active;      // Between a start and a stop, and addressed
  logic        addr_frame;  // First byte after start
  logic        reading;
  logic        rd_done;     // Master sent its nack
  logic        one_byte;    // Last write carried a single byte
  logic [1:0]  byte_no;     // Data byte index in this transaction
  logic [1:0]  next_no;
  logic [3:0]  bit_cnt;     // Rising edges seen in the current frame
  logic [7:0]  shreg;
  logic [7:0]  tx_byte;
  logic [7:0]  next_tx;
  logic [15:0] value;       // The one register
  int          hold_cnt;

  assign scl_rise   = !scl_q && scl;
  assign scl_fall   = scl_q && !scl;
  assign start_cond = scl_q && scl && sda_q && !sda;
  assign stop_cond  = scl_q && scl && !sda_q && sda;

  // Echo the written bytes in the order they arrived
  assign next_no = addr_frame ? 2'd0 : byte_no + 2'd1;
  assign next_tx = (next_no[0] ^ one_byte) ? value[7:0] : value[15:8];

  always @(posedge clk)
  begin
    scl_q <= scl;
    sda_q <= sda;
    if (rst)
    begin
      active   <= 1'b0;
      scl_oe   <= 1'b0;
      sda_oe   <= 1'b0;
      hold_cnt <= 0;
      value    <= 16'h0000;
      one_byte <= 1'b0;
      bit_cnt  <= 4'd0;
      reading  <= 1'b0;
    end
    else
    begin
      if (hold_cnt != 0)
      begin
        hold_cnt <= hold_cnt - 1;
        if (hold_cnt == 1)
        begin
          scl_oe <= 1'b0;  // Let SCL rise again
        end
      end

      if (start_cond)
      begin
        active     <= 1'b1;
        addr_frame <= 1'b1;
        reading    <= 1'b0;
        rd_done    <= 1'b0;
        byte_no    <= 2'd0;
        bit_cnt    <= 4'd0;
        sda_oe     <= 1'b0;
      end
      else if (stop_cond)
      begin
        active <= 1'b0;
        sda_oe <= 1'b0;
      end
      else if (active && scl_rise)
      begin
        if (bit_cnt < 4'd8)
        begin
          if (!reading)
          begin
            shreg <= {shreg[6:0], sda};
          end
        end
        else if (reading && !addr_frame && sda)
        begin
          rd_done <= 1'b1;  // No more bytes wanted
        end
        bit_cnt <= bit_cnt + 4'd1;
      end
      else if (active && scl_fall)
      begin
        if (bit_cnt == 4'd8)
        begin
          // Ninth bit, stretched whenever this target takes part
          if (addr_frame && (shreg[7:1] != dev_addr))
          begin
            active <= 1'b0;  // Someone else, wait for the next start
          end
          else
          begin
            scl_oe   <= 1'b1;
            hold_cnt <= hold_cycles;
            if (addr_frame)
            begin
              reading <= shreg[0];
              sda_oe  <= 1'b1;  // Address ack
            end
            else if (reading)
            begin
              sda_oe <= 1'b0;  // Master answers this one
            end
            else
            begin
              value    <= {value[7:0], shreg};
              one_byte <= (byte_no == 2'd0);
              sda_oe   <= 1'b1;  // Data ack
            end
          end
        end
        else if (bit_cnt == 4'd9)
        begin
          bit_cnt    <= 4'd0;
          addr_frame <= 1'b0;
          byte_no    <= next_no;
          if (reading && !rd_done)
          begin
            tx_byte <= next_tx;
            sda_oe  <= ~next_tx[7];
          end
          else
          begin
            sda_oe <= 1'b0;
          end
        end
        else if (reading && !rd_done)
        begin
          sda_oe <= ~tx_byte[3'd7 - bit_cnt[2:0]];  // MSB first
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_i2c.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2c;

  localparam logic [15:0] clk_div     = 16'd4;
  localparam logic [6:0]  target_addr = 7'h50;
  localparam int          rst_cycles  = 8;
  localparam int          drive_delay = 1;
  localparam int          max_txn     = 64;
  localparam int          fields      = 6;  // Words per stim line
  localparam int          txn_bound   = 40 * 4 * int'(clk_div) * 2;  // 40 bits, stretch x2

  logic        clk;
  logic        rst;
  logic        start;
  logic [6:0]  addr;
  logic [15:0] data;
  logic        two_bytes;
  logic        rw;

  wire         dut_scl_oe;
  wire         dut_sda_oe;
  wire         tgt_scl_oe;
  wire         tgt_sda_oe;
  wire         scl_bus;
  wire         sda_bus;
  wire [15:0]  read_data;
  wire         ready;
  wire         nack;

  logic [15:0] stim_mem [0:max_txn*fields-1];
  int          n_txn;
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  // Wired-AND with pull-ups
  assign scl_bus = !(dut_scl_oe || tgt_scl_oe);
  assign sda_bus = !(dut_sda_oe || tgt_sda_oe);

  tb_clk_gen #(.period_ns(4)) clk_gen_i (.clk(clk));

  i2c_sub_top #(
    .clk_div (clk_div)
  ) i2c_sub_top_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .addr      (addr),
    .data      (data),
    .two_bytes (two_bytes),
    .rw        (rw),
    .scl_in    (scl_bus),
    .sda_in    (sda_bus),
    .scl_oe    (dut_scl_oe),
    .sda_oe    (dut_sda_oe),
    .read_data (read_data),
    .ready     (ready),
    .nack      (nack)
  );

  i2c_target_model #(
    .dev_addr    (target_addr),
    .hold_cycles (2 * int'(clk_div) + 3)  // Three cycles past the master's low time
  ) target_i (
    .clk    (clk),
    .rst    (rst),
    .scl    (scl_bus),
    .sda    (sda_bus),
    .scl_oe (tgt_scl_oe),
    .sda_oe (tgt_sda_oe)
  );

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if ((cycle_limit > 0) && (cycles >= cycle_limit))
    begin
      $display("Timeout after %0d cycles, ready never came back", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input string what,
                             input logic [15:0] expected, input logic [15:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      $display("FAILED %s %s: expected %h, actual %h", name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic load_stim();
    int i;
    for (i = 0; i < max_txn * fields; i++)
    begin
      stim_mem[i] = 16'hffff;  // Marks unused lines
    end
    $readmemh("i2c_stim.txt", stim_mem);
    n_txn = 0;
    while ((n_txn < max_txn) && (stim_mem[fields*n_txn] != 16'hffff))
    begin
      n_txn++;
    end
  endtask

  task automatic wait_ready();
    while (!ready)
    begin
      @(posedge clk);
      #drive_delay;
    end
  endtask

  task automatic run_txn(input int idx);
    logic        t_rw;
    logic        t_two;
    logic        t_nack;
    logic [6:0]  t_addr;
    logic [15:0] t_wdata;
    logic [15:0] t_rdata;
    string       name;
    t_rw    = stim_mem[fields*idx][0];
    t_two   = stim_mem[fields*idx+1][0];
    t_addr  = stim_mem[fields*idx+2][6:0];
    t_wdata = stim_mem[fields*idx+3];
    t_rdata = stim_mem[fields*idx+4];
    t_nack  = stim_mem[fields*idx+5][0];
    name    = $sformatf("txn %0d", idx + 1);

    rw        = t_rw;
    two_bytes = t_two;
    addr      = t_addr;
    data      = t_wdata;
    start     = 1'b1;
    @(posedge clk);
    #drive_delay;
    start = 1'b0;
    check_value(name, "ready after start", 16'h0000, {15'd0, ready});

    if (t_rw)
    begin
      // A second request in flight must be dropped
      repeat (6) @(posedge clk);
      #drive_delay;
      rw        = 1'b0;
      two_bytes = 1'b1;
      addr      = target_addr;
      data      = 16'hffff;
      start     = 1'b1;
      @(posedge clk);
      #drive_delay;
      start = 1'b0;
    end

    wait_ready();
    check_value(name, "nack", {15'd0, t_nack}, {15'd0, nack});
    if (t_rw && !t_nack)
    begin
      check_value(name, "read_data", t_rdata, read_data);
    end
  endtask

  initial
  begin
    int i;
    rst       = 1'b1;
    start     = 1'b0;
    addr      = 7'd0;
    data      = 16'h0000;
    two_bytes = 1'b0;
    rw        = 1'b0;

    load_stim();
    assert (n_txn > 0)
    else
    begin
      $display("The stim file holds no transactions");
      errors++;
    end
    cycle_limit = n_txn * txn_bound + rst_cycles + 100;

    repeat (rst_cycles) @(posedge clk);
    #drive_delay;
    rst = 1'b0;
    check_value("reset", "ready", 16'h0001, {15'd0, ready});
    check_value("reset", "nack", 16'h0000, {15'd0, nack});
    check_value("reset", "scl_oe", 16'h0000, {15'd0, dut_scl_oe});
    check_value("reset", "sda_oe", 16'h0000, {15'd0, dut_sda_oe});

    for (i = 0; i < n_txn; i++)
    begin
      run_txn(i);
    end

    $display("Finished %0d transactions: %0d checks, %0d errors", n_txn, checks, errors);
    if (errors == 0)
    begin
      $display("ALL TESTS PASSED");
    end
    else
    begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: i2c_sub_top.f
i2c_pkg.sv
i2c_scl_gen.sv
i2c_master.sv
i2c_sub_top.sv
tb_clk_gen.sv
i2c_target_model.sv
tb_i2c.sv

// File: run.sh
#!/usr/bin/env bash
# Build the I2C subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f i2c_sub_top.f --top-module tb_i2c -o sim_tb_i2c \
  || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/sim_tb_i2c)"
echo "$sim_out"
echo "$sim_out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1

// File: i2c_stim.txt
// rw two_bytes addr wdata exp_rdata exp_nack, all hex, one transaction per line
// Target at 50 echoes the bytes of its last write, a read moves the MSB byte first
0 0 50 005a 0000 0
1 0 50 0000 005a 0
0 1 50 a5c3 0000 0
1 1 50 0000 a5c3 0
0 1 23 1234 0000 1
1 1 50 0000 a5c3 0
1 0 7f 0000 0000 1
1 0 50 0000 00a5 0
0 1 50 8001 0000 0
1 1 50 0000 8001 0
0 0 51 00ff 0000 1
0 0 50 003c 0000 0
1 0 50 0000 003c 0
1 0 50 0000 003c 0
